//--- Bender.yml
package:
  name: slot_bus

sources:
  - a2slot_pkg.sv
  - slotmaker.sv
  - register_card.sv
  - ram_card.sv
  - card_data_arbiter.sv
  - slot_bus_top.sv
  - target: simulation
    files:
      - slot_bus_asserts.sv
      - slot_bus_tb.sv

//--- a2slot_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the virtual card slot subsystem
// Bus cycle, soft switch, decoded select and read return structs
// Referenced by scoped names from the slot controller and cards
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package a2slot_pkg;

    // Apple II address and data widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // Slot number 0 to 7
    typedef logic [2:0]  slot_t;

    // Virtual card identifier, zero marks an empty slot
    typedef logic [7:0]  card_id_t;

    // One bus cycle as seen at the slot connector
    typedef struct packed {
        addr_t addr;
        data_t data;
        logic  rw_n;       // Low for a write
        logic  m2sel_n;    // Low for a valid cycle
    } bus_cycle_t;

    // Soft switch levels from the memory controller
    typedef struct packed {
        logic intcxrom;
        logic intc8rom;
    } mem_sw_t;

    // Registered decode of one cycle, fanned out to every card
    typedef struct packed {
        slot_t    slot;
        card_id_t card_id;
        logic     devselect_n;
        logic     ioselect_n;
        logic     iostrobe_n;
        logic     cfff_hit;    // Access to $CFFF, releases the C8 window
        addr_t    addr;
        data_t    data;
        logic     rw_n;
    } slot_sel_t;

    // Read return of a single card
    typedef struct packed {
        logic  valid;
        data_t data;
    } card_rd_t;

endpackage

//--- card_data_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Merges the card read returns onto the bus data output
// Register card wins when both answer, and the clash is flagged
// Purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module card_data_arbiter (
    input  a2slot_pkg::card_rd_t reg_rd,
    input  a2slot_pkg::card_rd_t ram_rd,
    output a2slot_pkg::data_t    rd_data,
    output logic                 rd_valid,
    output logic                 bus_conflict
);

    always_comb begin
        // Fixed priority, register card first
        if (reg_rd.valid) begin
            rd_data = reg_rd.data;
        end else if (ram_rd.valid) begin
            rd_data = ram_rd.data;
        end else begin
            // Idle bus reads as zero
            rd_data = '0;
        end

        rd_valid     = reg_rd.valid || ram_rd.valid;
        // Two cards driving one cycle means a bad table setup
        bus_conflict = reg_rd.valid && ram_rd.valid;
    end

endmodule

//--- ram_card.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Virtual RAM card with a 256 byte slot page and a 2 KB
// expansion window at $C800-$CFFF
// The window is claimed by an I/O select to this card and
// released by any access to $CFFF
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ram_card #(
    parameter a2slot_pkg::card_id_t CARD_ID = 8'd2
) (
    input  logic                  a2bus_if,
    input  logic                  rst_n,
    input  a2slot_pkg::slot_sel_t sel,
    output a2slot_pkg::card_rd_t  rd
);

    localparam int PAGE_DEPTH = 256;
    localparam int WIN_DEPTH  = 2048;

    // Power-up contents are zero
    a2slot_pkg::data_t page_mem [PAGE_DEPTH] = '{default: '0};
    a2slot_pkg::data_t win_mem  [WIN_DEPTH]  = '{default: '0};

    logic              owned;
    logic              page_hit;
    logic              win_hit;
    logic [7:0]        page_idx;
    logic [10:0]       win_idx;
    logic              rd_valid_q;
    a2slot_pkg::data_t rd_data_q;

    always_comb begin
        page_hit = !sel.ioselect_n && (sel.card_id == CARD_ID);
        // Strobe reaches every card, only the owner answers
        win_hit  = !sel.iostrobe_n && owned;
        page_idx = sel.addr[7:0];
        win_idx  = sel.addr[10:0];
    end

    // Expansion window ownership
    always_ff @(posedge a2bus_if or negedge rst_n) begin
        if (!rst_n) begin
            owned <= 1'b0;
        end else if (page_hit) begin
            owned <= 1'b1;
        end else if (sel.cfff_hit) begin
            // Access at $CFFF itself still used the old ownership
            owned <= 1'b0;
        end
    end

    // Page and window RAMs with registered read data
    always_ff @(posedge a2bus_if) begin
        if (page_hit && !sel.rw_n) begin
            page_mem[page_idx] <= sel.data;
        end
        if (win_hit && !sel.rw_n) begin
            win_mem[win_idx] <= sel.data;
        end
        if (page_hit) begin
            rd_data_q <= page_mem[page_idx];
        end else begin
            rd_data_q <= win_mem[win_idx];
        end
    end

    always_ff @(posedge a2bus_if or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (page_hit || win_hit) && sel.rw_n;
        end
    end

    always_comb begin
        rd.valid = rd_valid_q;
        rd.data  = rd_data_q;
    end

endmodule

//--- register_card.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Virtual register card with sixteen byte registers in its
// slot device space $C0n0-$C0nF
// Answers only cycles whose card_id matches CARD_ID
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module register_card #(
    parameter a2slot_pkg::card_id_t CARD_ID = 8'd1
) (
    input  logic                  a2bus_if,
    input  logic                  rst_n,
    input  a2slot_pkg::slot_sel_t sel,
    output a2slot_pkg::card_rd_t  rd
);

    a2slot_pkg::data_t regs [16];

    logic       dev_hit;
    logic [3:0] reg_idx;

    always_comb begin
        // Device select routed to this card
        dev_hit = !sel.devselect_n && (sel.card_id == CARD_ID);
        reg_idx = sel.addr[3:0];
    end

    // Register file
    always_ff @(posedge a2bus_if or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (dev_hit && !sel.rw_n) begin
            regs[reg_idx] <= sel.data;
        end
    end

    // Read return, valid for a single cycle
    always_ff @(posedge a2bus_if or negedge rst_n) begin
        if (!rst_n) begin
            rd <= '0;
        end else begin
            rd.valid <= dev_hit && sel.rw_n;
            rd.data  <= regs[reg_idx];
        end
    end

endmodule

//--- sim.f
a2slot_pkg.sv
slotmaker.sv
register_card.sv
ram_card.sv
card_data_arbiter.sv
slot_bus_top.sv
slot_bus_asserts.sv
slot_bus_tb.sv

//--- slot_bus_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the slot selects and the read merge
// Bound into the top level next to slotmaker and the arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module slot_bus_asserts (
    input logic                  a2bus_if,
    input logic                  rst_n,
    input a2slot_pkg::slot_sel_t sel,
    input logic                  rd_valid,
    input logic                  bus_conflict
);
    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed assertions
    int fail_count = 0;

    // Device, I/O and strobe selects never overlap
    sel_one_hot: assert property (@(posedge a2bus_if) disable iff (!rst_n)
        $onehot0({!sel.devselect_n, !sel.ioselect_n, !sel.iostrobe_n}))
    else begin
        fail_count++;
        $error("more than one slot select active");
    end

    // First cycle out of reset carries no select
    sel_idle_after_reset: assert property (@(posedge a2bus_if)
        $rose(rst_n) |-> (sel.devselect_n && sel.ioselect_n && sel.iostrobe_n))
    else begin
        fail_count++;
        $error("select active right after reset release");
    end

    // A clash only exists on a cycle with read data
    conflict_has_valid: assert property (@(posedge a2bus_if) disable iff (!rst_n)
        bus_conflict |-> rd_valid)
    else begin
        fail_count++;
        $error("bus_conflict without rd_valid");
    end

endmodule

// sel comes from slotmaker, rd_valid and bus_conflict from the arbiter
bind slot_bus_top slot_bus_asserts u_asserts (
    .a2bus_if    (a2bus_if),
    .rst_n       (rst_n),
    .sel         (sel),
    .rd_valid    (rd_valid),
    .bus_conflict(bus_conflict)
);

//--- slot_bus_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the virtual slot bus top level
// Drives directed and random bus cycles on the falling edge,
// predicts every read return with a reference model and
// compares the DUT outputs two cycles after each cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module slot_bus_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Slot 3 holds the register card, slot 6 the RAM card
    localparam logic [63:0] SLOT_CARDS = 64'h0002_0000_0100_0000;
    localparam a2slot_pkg::card_id_t REG_ID = 8'd1;
    localparam a2slot_pkg::card_id_t RAM_ID = 8'd2;
    localparam int NUM_RANDOM = 400;
    // Reset plus directed sections, random mix and a drain margin
    localparam int MAX_CYCLES = 10 + 200 + NUM_RANDOM + 50;

    // Predicted read return due at a given cycle count
    typedef struct packed {
        logic [31:0]       due;
        logic              valid;
        a2slot_pkg::data_t data;
        logic              conflict;
    } rd_exp_t;

    typedef struct packed {
        logic [31:0]          due;
        a2slot_pkg::card_id_t card;
    } cfg_exp_t;

    logic                   a2bus_if;
    logic                   rst_n;
    a2slot_pkg::bus_cycle_t bus;
    a2slot_pkg::mem_sw_t    mem_sw;
    logic                   cfg_wr;
    a2slot_pkg::slot_t      cfg_slot;
    a2slot_pkg::card_id_t   cfg_card;
    a2slot_pkg::card_id_t   cfg_card_o;
    a2slot_pkg::data_t      rd_data;
    logic                   rd_valid;
    logic                   bus_conflict;

    // Reference model state
    a2slot_pkg::card_id_t m_table [8];
    a2slot_pkg::data_t    m_regs [16]  = '{default: '0};
    a2slot_pkg::data_t    m_page [256] = '{default: '0};
    a2slot_pkg::data_t    m_win [2048] = '{default: '0};
    logic                 m_owned = 1'b0;

    rd_exp_t             rd_q [$];
    cfg_exp_t            cfg_q [$];
    a2slot_pkg::mem_sw_t sw_next;
    logic [31:0]         rng = 32'd97237;
    int unsigned         cyc = 0;

    slot_bus_top #(
        .SLOT_CARDS (SLOT_CARDS),
        .REG_CARD_ID(REG_ID),
        .RAM_CARD_ID(RAM_ID)
    ) uut (
        .a2bus_if    (a2bus_if),
        .rst_n       (rst_n),
        .bus         (bus),
        .mem_sw      (mem_sw),
        .cfg_wr      (cfg_wr),
        .cfg_slot    (cfg_slot),
        .cfg_card    (cfg_card),
        .cfg_card_o  (cfg_card_o),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .bus_conflict(bus_conflict)
    );

    initial begin
        a2bus_if = 1'b0;
        forever #2 a2bus_if = ~a2bus_if;
    end

    // Cycle counter that also guards against a hang
    always @(posedge a2bus_if) begin
        cyc <= cyc + 1;
        if (cyc > MAX_CYCLES) begin
            report_failure("Run passed its cycle limit without finishing");
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input a2slot_pkg::data_t got,
                              input a2slot_pkg::data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_card(input string name, input a2slot_pkg::card_id_t got,
                              input a2slot_pkg::card_id_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // Reference model of one cycle, applied in presentation order
    function automatic rd_exp_t model_cycle(input a2slot_pkg::bus_cycle_t c,
                                            input a2slot_pkg::mem_sw_t sw);
        rd_exp_t              e;
        logic                 live;
        logic                 reg_v;
        logic                 ram_v;
        a2slot_pkg::data_t    ram_d;
        a2slot_pkg::card_id_t id;
        e     = '0;
        reg_v = 1'b0;
        ram_v = 1'b0;
        ram_d = '0;
        live  = !c.m2sel_n;
        if (live && c.addr >= 16'hC080 && c.addr <= 16'hC0FF) begin
            // Device space holds sixteen bytes per slot
            id = m_table[c.addr[6:4]];
            if (id == REG_ID && c.rw_n) begin
                reg_v  = 1'b1;
                e.data = m_regs[c.addr[3:0]];
            end else if (id == REG_ID) begin
                m_regs[c.addr[3:0]] = c.data;
            end
        end else if (live && c.addr >= 16'hC100 && c.addr <= 16'hC7FF) begin
            id = m_table[c.addr[10:8]];
            // I/O space is hidden by intcxrom and the RAM card claims the window here
            if (id == RAM_ID && !sw.intcxrom) begin
                m_owned = 1'b1;
                ram_v   = c.rw_n;
                ram_d   = m_page[c.addr[7:0]];
                if (!c.rw_n) begin
                    m_page[c.addr[7:0]] = c.data;
                end
            end
        end else if (live && c.addr >= 16'hC800 && c.addr <= 16'hCFFF) begin
            if (m_owned && !sw.intcxrom && !sw.intc8rom) begin
                ram_v = c.rw_n;
                ram_d = m_win[c.addr[10:0]];
                if (!c.rw_n) begin
                    m_win[c.addr[10:0]] = c.data;
                end
            end
            // Any touch of $CFFF gives the window up afterwards
            if (c.addr == 16'hCFFF) begin
                m_owned = 1'b0;
            end
        end
        e.valid = reg_v || ram_v;
        if (!reg_v && ram_v) begin
            e.data = ram_d;
        end
        e.conflict = reg_v && ram_v;
        return e;
    endfunction

    // Present one cycle at the falling edge and queue its predictions
    task automatic drive_cycle(input a2slot_pkg::bus_cycle_t c, input logic wr,
                               input logic cfg_rd, input a2slot_pkg::slot_t s,
                               input a2slot_pkg::card_id_t card);
        rd_exp_t  e;
        cfg_exp_t ce;
        @(negedge a2bus_if);
        bus      = c;
        mem_sw   = sw_next;
        cfg_wr   = wr;
        cfg_slot = s;
        cfg_card = card;
        e        = model_cycle(c, sw_next);
        e.due    = cyc + 2;
        rd_q.push_back(e);
        if (cfg_rd) begin
            // Readback shows the entry ahead of a same-edge write
            ce.card = m_table[s];
            ce.due  = cyc + 1;
            cfg_q.push_back(ce);
        end
        if (wr) begin
            m_table[s] = card;
        end
    endtask

    task automatic bus_access(input logic rw_n, input a2slot_pkg::addr_t a,
                              input a2slot_pkg::data_t d);
        drive_cycle({a, d, rw_n, 1'b0}, 1'b0, 1'b0, '0, '0);
    endtask

    // Idle bus cycle carrying a table write or readback
    task automatic table_access(input logic wr, input a2slot_pkg::slot_t s,
                                input a2slot_pkg::card_id_t card);
        drive_cycle({16'h0000, 8'h00, 1'b1, 1'b1}, wr, 1'b1, s, card);
    endtask

    // Compare the outputs due at this falling edge
    always @(negedge a2bus_if) begin
        rd_exp_t  e;
        cfg_exp_t ce;
        while (rd_q.size() != 0 && rd_q[0].due == cyc) begin
            e = rd_q.pop_front();
            check_flag("rd_valid", rd_valid, e.valid);
            check_data("rd_data", rd_data, e.data);
            check_flag("bus_conflict", bus_conflict, e.conflict);
        end
        while (cfg_q.size() != 0 && cfg_q[0].due == cyc) begin
            ce = cfg_q.pop_front();
            check_card("cfg_card_o", cfg_card_o, ce.card);
        end
    end

    initial begin
        a2slot_pkg::addr_t a;
        logic [31:0]       r;
        logic [31:0]       q;
        rst_n    = 1'b0;
        bus      = {16'h0000, 8'h00, 1'b1, 1'b1};
        mem_sw   = '0;
        sw_next  = '0;
        cfg_wr   = 1'b0;
        cfg_slot = '0;
        cfg_card = '0;
        for (int i = 0; i < 8; i++) begin
            m_table[i] = SLOT_CARDS[i*8 +: 8];
        end
        repeat (10) @(posedge a2bus_if);
        @(negedge a2bus_if);
        rst_n = 1'b1;

        // Register card in slot 3 and then silent empty slots
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            bus_access(1'b0, {12'hC0B, i[3:0]}, r[23:16]);
        end
        for (int i = 0; i < 16; i++) begin
            bus_access(1'b1, {12'hC0B, i[3:0]}, '0);
        end
        bus_access(1'b1, 16'hC095, '0);
        bus_access(1'b1, 16'hC0A5, '0);
        bus_access(1'b1, 16'hC0C5, '0);
        bus_access(1'b1, 16'hC0F5, '0);

        // Move the register card from slot 3 to slot 5
        table_access(1'b1, 3'd5, REG_ID);
        table_access(1'b1, 3'd3, 8'd0);
        table_access(1'b0, 3'd5, '0);
        table_access(1'b0, 3'd3, '0);
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            bus_access(1'b0, {12'hC0D, i[3:0]}, r[15:8]);
            bus_access(1'b1, {12'hC0D, i[3:0]}, '0);
            bus_access(1'b1, {12'hC0B, i[3:0]}, '0);
        end

        // RAM card slot page and then the page hidden behind intcxrom
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            bus_access(1'b0, {8'hC6, r[31:24]}, r[23:16]);
            bus_access(1'b1, {8'hC6, r[31:24]}, '0);
        end
        sw_next.intcxrom = 1'b1;
        for (int i = 0; i < 8; i++) begin
            bus_access(1'b1, {8'hC6, i[3:0], 4'h0}, '0);
        end
        sw_next = '0;

        // Window released then claimed through slot 6, blocked and released again
        bus_access(1'b1, 16'hCFFF, '0);
        for (int i = 0; i < 4; i++) begin
            bus_access(1'b1, {6'b110010, i[9:0]}, '0);
        end
        bus_access(1'b1, 16'hC600, '0);
        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            bus_access(1'b0, {6'b110010, r[25:16]}, r[31:24]);
            bus_access(1'b1, {6'b110010, r[25:16]}, '0);
        end
        sw_next.intc8rom = 1'b1;
        for (int i = 0; i < 4; i++) begin
            bus_access(1'b1, {6'b110010, i[9:0]}, '0);
        end
        sw_next = '0;
        bus_access(1'b1, 16'hCFFF, '0);
        for (int i = 0; i < 4; i++) begin
            bus_access(1'b1, {6'b110010, i[9:0]}, '0);
        end

        // Random back to back mix over every address region
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = lcg_next();
            q = lcg_next();
            case (r[31:29])
                3'd0:       a = {12'hC0D, r[19:16]};
                3'd1:       a = {9'b1100_0000_1, r[22:16]};
                3'd2:       a = {8'hC6, r[23:16]};
                3'd3:       a = {5'b11000, r[26:16]};
                3'd4, 3'd5: a = {5'b11001, r[26:16]};
                3'd6:       a = 16'hCFFF;
                default:    a = r[27:12];
            endcase
            sw_next.intcxrom = (q[31:29] == 3'd0);
            sw_next.intc8rom = (q[28:26] == 3'd0);
            bus_access(q[25], a, q[23:16]);
        end

        // Park the bus and let the last predictions come due
        sw_next = '0;
        table_access(1'b0, 3'd6, '0);
        while (rd_q.size() != 0 || cfg_q.size() != 0) begin
            @(negedge a2bus_if);
        end
        if (uut.u_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            report_failure("One or more bound assertions failed during the run");
        end
    end

endmodule

//--- slot_bus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the virtual slot bus
// Slot controller feeds both cards, the arbiter merges reads
// Read data appears two cycles after a bus cycle is sampled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module slot_bus_top #(
    parameter logic [63:0]          SLOT_CARDS  = '0,
    parameter a2slot_pkg::card_id_t REG_CARD_ID = 8'd1,
    parameter a2slot_pkg::card_id_t RAM_CARD_ID = 8'd2
) (
    input  logic                   a2bus_if,
    input  logic                   rst_n,
    input  a2slot_pkg::bus_cycle_t bus,
    input  a2slot_pkg::mem_sw_t    mem_sw,
    input  logic                   cfg_wr,
    input  a2slot_pkg::slot_t      cfg_slot,
    input  a2slot_pkg::card_id_t   cfg_card,
    output a2slot_pkg::card_id_t   cfg_card_o,
    output a2slot_pkg::data_t      rd_data,
    output logic                   rd_valid,
    output logic                   bus_conflict
);

    // Decoded cycle shared by all cards
    a2slot_pkg::slot_sel_t sel;
    a2slot_pkg::card_rd_t  reg_rd;
    a2slot_pkg::card_rd_t  ram_rd;

    slotmaker #(
        .SLOT_CARDS(SLOT_CARDS)
    ) u_slotmaker (
        .a2bus_if  (a2bus_if),
        .rst_n     (rst_n),
        .bus       (bus),
        .mem_sw    (mem_sw),
        .cfg_wr    (cfg_wr),
        .cfg_slot  (cfg_slot),
        .cfg_card  (cfg_card),
        .cfg_card_o(cfg_card_o),
        .sel       (sel)
    );

    register_card #(
        .CARD_ID(REG_CARD_ID)
    ) u_register_card (
        .a2bus_if(a2bus_if),
        .rst_n   (rst_n),
        .sel     (sel),
        .rd      (reg_rd)
    );

    ram_card #(
        .CARD_ID(RAM_CARD_ID)
    ) u_ram_card (
        .a2bus_if(a2bus_if),
        .rst_n   (rst_n),
        .sel     (sel),
        .rd      (ram_rd)
    );

    card_data_arbiter u_card_data_arbiter (
        .reg_rd      (reg_rd),
        .ram_rd      (ram_rd),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .bus_conflict(bus_conflict)
    );

endmodule

//--- slotmaker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot controller: decodes each bus cycle into device, I/O
// and expansion space, looks the slot up in a writable card
// table and registers the active-low selects for the cards
// Table is loaded with SLOT_CARDS on reset, rewritten via cfg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module slotmaker #(
    // Eight bytes, slot 0 in the low byte
    parameter logic [63:0] SLOT_CARDS = '0
) (
    input  logic                   a2bus_if,
    input  logic                   rst_n,
    input  a2slot_pkg::bus_cycle_t bus,
    input  a2slot_pkg::mem_sw_t    mem_sw,
    input  logic                   cfg_wr,
    input  a2slot_pkg::slot_t      cfg_slot,
    input  a2slot_pkg::card_id_t   cfg_card,
    output a2slot_pkg::card_id_t   cfg_card_o,
    output a2slot_pkg::slot_sel_t  sel
);

    // $C080-$C0FF, slot in addr[6:4]
    localparam logic [8:0] DEV_SPACE = 9'b1100_0000_1;
    // $C100-$C7FF, slot in addr[10:8]
    localparam logic [4:0] IO_SPACE  = 5'b1100_0;
    // $C800-$CFFF, shared expansion window
    localparam logic [4:0] C8_SPACE  = 5'b1100_1;
    localparam a2slot_pkg::addr_t CFFF_ADDR = 16'hCFFF;

    a2slot_pkg::card_id_t card_table [8];
    a2slot_pkg::slot_t    last_io_slot;

    logic                 cyc_valid;
    logic                 dev_space;
    logic                 io_space;
    logic                 c8_space;
    a2slot_pkg::slot_t    slot_dec;
    a2slot_pkg::card_id_t card_dec;
    logic                 devsel_n;
    logic                 iosel_n;
    logic                 strobe_n;
    logic                 cfff;

    always_comb begin
        cyc_valid = !bus.m2sel_n;
        dev_space = cyc_valid && (bus.addr[15:7] == DEV_SPACE);
        // Page $C0 shares the top bits with I/O space, so slot 0 is excluded
        io_space  = cyc_valid && (bus.addr[15:11] == IO_SPACE) && (bus.addr[10:8] != 3'd0);
        c8_space  = cyc_valid && (bus.addr[15:11] == C8_SPACE);
        cfff      = cyc_valid && (bus.addr == CFFF_ADDR);

        // Expansion cycles belong to the slot that last had an I/O select
        if (dev_space) begin
            slot_dec = bus.addr[6:4];
        end else if (io_space) begin
            slot_dec = bus.addr[10:8];
        end else begin
            slot_dec = last_io_slot;
        end
        card_dec = card_table[slot_dec];

        // Selects need a card present, I/O and strobe also obey the switches
        devsel_n = !(dev_space && (card_dec != '0));
        iosel_n  = !(io_space && (card_dec != '0) && !mem_sw.intcxrom);
        strobe_n = !(c8_space && !mem_sw.intcxrom && !mem_sw.intc8rom);
    end

    // Card table, config readback and expansion owner slot
    always_ff @(posedge a2bus_if or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                card_table[i] <= SLOT_CARDS[i*8 +: 8];
            end
            cfg_card_o   <= '0;
            last_io_slot <= '0;
        end else begin
            // Readback shows the entry before a same-edge write
            cfg_card_o <= card_table[cfg_slot];
            if (cfg_wr) begin
                card_table[cfg_slot] <= cfg_card;
            end
            if (!iosel_n) begin
                last_io_slot <= slot_dec;
            end
        end
    end

    // One cycle of decode latency toward the cards
    always_ff @(posedge a2bus_if or negedge rst_n) begin
        if (!rst_n) begin
            sel             <= '0;
            sel.devselect_n <= 1'b1;
            sel.ioselect_n  <= 1'b1;
            sel.iostrobe_n  <= 1'b1;
        end else begin
            sel.slot        <= slot_dec;
            sel.card_id     <= card_dec;
            sel.devselect_n <= devsel_n;
            sel.ioselect_n  <= iosel_n;
            sel.iostrobe_n  <= strobe_n;
            sel.cfff_hit    <= cfff;
            sel.addr        <= bus.addr;
            sel.data        <= bus.data;
            sel.rw_n        <= bus.rw_n;
        end
    end

endmodule
